// File: Makefile
VERILATOR ?= verilator
TOP       ?= blur_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/blur_tb.sv
`timescale 1ns/10ps
`default_nettype none

module blur_tb;
    import blur_pkg::*;

    localparam int WAIT_LIMIT = 1000;
    localparam logic [31:0] SEED = 32'hf46c8c81;

    logic      clk;
    logic      arst_n;
    logic      in_valid;
    logic      in_ready;
    pix_beat_t in_beat;
    logic      mask_frame;
    logic      out_valid;
    logic      out_ready;
    pix_beat_t out_beat;

    // current input frame, kept for the reference model
    rgb_t      frame_mem [IMG_H][IMG_W];
    // expected output beats with a label per beat
    pix_beat_t exp_q [$];
    string     name_q [$];
    int        errors;
    int        in_count;
    int        out_count;
    bit        stall_en;
    // set once a wait runs out, the sequence stops there
    bit        timed_out;

    clk_gen #(.PERIOD_NS(10), .RESET_CYCLES(5)) u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    blur_top dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .mask_frame (mask_frame),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat)
    );

    // causal 5x5 mean, pixels outside the frame count as zero, sum*41>>10
    function automatic rgb_t ref_blur(input int row, input int col);
        int   sr;
        int   sg;
        int   sb;
        rgb_t q;
        rgb_t p;
        sr = 0;
        sg = 0;
        sb = 0;
        for (int dr = 0; dr < KERNEL_DIM; dr++) begin
            for (int dc = 0; dc < KERNEL_DIM; dc++) begin
                if (row - dr >= 0 && col - dc >= 0) begin
                    q = frame_mem[row-dr][col-dc];
                    sr += int'(q.r);
                    sg += int'(q.g);
                    sb += int'(q.b);
                end
            end
        end
        p.r = 4'((sr * NORM_MUL) >> NORM_SHIFT);
        p.g = 4'((sg * NORM_MUL) >> NORM_SHIFT);
        p.b = 4'((sb * NORM_MUL) >> NORM_SHIFT);
        return p;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d, beats in: %0d, beats out: %0d", errors, in_count, out_count);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // entered and left on a falling edge
    task automatic send_beat(input pix_beat_t b, input logic m, input bit gaps);
        int idle;
        int waited;
        bit accepted;
        idle = gaps ? int'($urandom % 3) : 0;
        for (int i = 0; i < idle; i++) begin
            in_valid = 1'b0;
            @(negedge clk);
        end
        in_valid   = 1'b1;
        in_beat    = b;
        mask_frame = m;
        waited     = 0;
        accepted   = 1'b0;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            accepted = in_ready;
            waited++;
        end
        if (!accepted) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: the DUT never took an input beat");
            return;
        end
        in_count++;
        @(negedge clk);
    endtask

    // fill 0 gives random pixels, fill 1 gives all 15s
    task automatic send_frame(input string name, input int fill, input logic mask,
                              input bit gaps, input bit toggle);
        pix_beat_t b;
        pix_beat_t e;
        logic      mv;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                frame_mem[r][c] = (fill == 1) ? 12'hfff : 12'($urandom);
            end
        end
        // expected beats are queued before the first one goes in
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                e.pix = mask ? ref_blur(r, c) : frame_mem[r][c];
                e.sop = (r == 0 && c == 0);
                e.eop = (r == IMG_H - 1 && c == IMG_W - 1);
                exp_q.push_back(e);
                name_q.push_back($sformatf("%s r%0d c%0d", name, r, c));
            end
        end
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                b.pix = frame_mem[r][c];
                b.sop = (r == 0 && c == 0);
                b.eop = (r == IMG_H - 1 && c == IMG_W - 1);
                // flip the flag halfway, it must not matter before the next sop
                mv = (toggle && r >= IMG_H / 2) ? !mask : mask;
                send_beat(b, mv, gaps);
                if (timed_out) begin
                    return;
                end
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(input string name);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: %0d beats of %s never came out", exp_q.size(), name);
        end
    endtask

    // whole test sequence, left early when a wait runs out
    task automatic run_tests();
        int waited;
        int in_before;
        int out_before;
        pix_beat_t b;
        waited = 0;
        while (!arst_n && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!arst_n) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: reset was never released");
            return;
        end
        @(negedge clk);
        check_equal("ready after reset", 32'd1, 32'(in_ready));

        // stray beats before any sop are swallowed
        out_before = out_count;
        for (int i = 0; i < 6; i++) begin
            b.pix = 12'($urandom);
            b.sop = 1'b0;
            b.eop = (i == 5);
            send_beat(b, 1'b1, 1'b0);
            if (timed_out) begin
                return;
            end
        end
        in_valid = 1'b0;
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
        end
        check_equal("pre-sop drop", 32'd0, 32'(out_count - out_before));

        send_frame("pass-through", 0, 1'b0, 1'b0, 1'b0);
        if (timed_out) begin
            return;
        end
        wait_drain("pass-through");
        if (timed_out) begin
            return;
        end
        send_frame("random blur", 0, 1'b1, 1'b0, 1'b0);
        if (timed_out) begin
            return;
        end
        wait_drain("random blur");
        if (timed_out) begin
            return;
        end
        send_frame("flat blur", 1, 1'b1, 1'b0, 1'b0);
        if (timed_out) begin
            return;
        end
        wait_drain("flat blur");
        if (timed_out) begin
            return;
        end

        // gaps on the input and stalls on the output, two frames back to back
        in_before  = in_count;
        out_before = out_count;
        stall_en   = 1'b1;
        send_frame("stall frame 0", 0, 1'b1, 1'b1, 1'b0);
        if (timed_out) begin
            return;
        end
        send_frame("stall frame 1", 0, 1'b1, 1'b1, 1'b0);
        if (timed_out) begin
            return;
        end
        wait_drain("stall frames");
        if (timed_out) begin
            return;
        end
        stall_en = 1'b0;
        check_equal("stall beat count", 32'(in_count - in_before), 32'(out_count - out_before));

        // mask alternates per frame and flips mid-frame
        for (int f = 0; f < 4; f++) begin
            send_frame($sformatf("toggle frame %0d", f), 0, f[0], 1'b0, 1'b1);
            if (timed_out) begin
                return;
            end
        end
        wait_drain("toggle frames");
    endtask

    // output monitor, pops one expected beat per output transfer
    initial begin
        pix_beat_t e;
        string     n;
        forever begin
            @(posedge clk);
            if (arst_n && out_valid && out_ready) begin
                out_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected output beat %h with nothing left to expect",
                             out_beat);
                end else begin
                    e = exp_q.pop_front();
                    n = name_q.pop_front();
                    check_equal(n, 32'(e), 32'(out_beat));
                end
            end
        end
    end

    // sink back-pressure, roughly one stalled cycle in four
    initial begin
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            out_ready = stall_en ? (($urandom % 4) != 0) : 1'b1;
        end
    end

    initial begin
        void'($urandom(SEED));
        in_valid   = 1'b0;
        in_beat    = '0;
        mask_frame = 1'b0;
        stall_en   = 1'b0;
        timed_out  = 1'b0;
        errors     = 0;
        in_count   = 0;
        out_count  = 0;
        run_tests();
        finish_run();
    end

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the flops
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: hw/blur_pkg.sv
`default_nettype none

package blur_pkg;

    // frame geometry, fixed at build time
    localparam int IMG_W = 32;
    localparam int IMG_H = 24;
    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(IMG_H);

    // causal 5x5 window edge
    localparam int KERNEL_DIM = 5;

    // rgb444 channel width
    localparam int CH_W = 4;
    // 25 taps of 15 give 375 at most
    localparam int SUM_W = 9;

    // sum * 41 >> 10 is a floor approximation of sum / 25
    localparam int NORM_MUL = 41;
    localparam int NORM_SHIFT = 10;

    typedef struct packed {
        logic [CH_W-1:0] r;
        logic [CH_W-1:0] g;
        logic [CH_W-1:0] b;
    } rgb_t;

    // external stream beat with packet markers
    typedef struct packed {
        rgb_t pix;
        logic sop;
        logic eop;
    } pix_beat_t;

    // beat tagged with its position and the frame's mask flag
    typedef struct packed {
        pix_beat_t        beat;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic             mask;
    } framed_t;

    // original beat plus raw window sums per channel
    typedef struct packed {
        pix_beat_t        beat;
        logic             mask;
        logic [SUM_W-1:0] sum_r;
        logic [SUM_W-1:0] sum_g;
        logic [SUM_W-1:0] sum_b;
    } sum_t;

endpackage

`default_nettype wire

// File: hw/blur_select.sv
`timescale 1ns/10ps
`default_nettype none

module blur_select (
    input  blur_pkg::sum_t      in_data,
    output blur_pkg::pix_beat_t out_beat
);
    import blur_pkg::*;

    rgb_t blurred;

    // floor(s * 41 / 1024), never above 15 for s <= 375
    function automatic logic [CH_W-1:0] norm_ch(input logic [SUM_W-1:0] s);
        logic [31:0] prod;
        prod = 32'(s) * 32'(NORM_MUL);
        return CH_W'(prod >> NORM_SHIFT);
    endfunction

    always_comb begin
        blurred.r = norm_ch(in_data.sum_r);
        blurred.g = norm_ch(in_data.sum_g);
        blurred.b = norm_ch(in_data.sum_b);
    end

    always_comb begin
        // markers always follow the original beat
        out_beat = in_data.beat;
        if (in_data.mask) begin
            out_beat.pix = blurred;
        end
    end

endmodule

`default_nettype wire

// File: hw/blur_top.sv
`timescale 1ns/10ps
`default_nettype none

module blur_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  blur_pkg::pix_beat_t in_beat,
    input  logic                mask_frame,
    output logic                out_valid,
    input  logic                out_ready,
    output blur_pkg::pix_beat_t out_beat
);
    import blur_pkg::*;

    // framer to s1
    logic      fr_valid;
    framed_t   fr_data;
    logic      s1_ready;
    // s1 to window summer and s2
    logic      s1_valid;
    framed_t   s1_data;
    logic      s2_ready;
    sum_t      sum_data;
    // s2 to selector and s3
    logic      s2_valid;
    sum_t      s2_data;
    logic      s3_ready;
    pix_beat_t sel_beat;
    // line buffers move only when s1 hands its beat to s2
    logic      advance;

    assign advance = s1_valid && s2_ready;

    pix_framer u_framer (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_beat    (in_beat),
        .mask_frame (mask_frame),
        .out_valid  (fr_valid),
        .out_ready  (s1_ready),
        .out_data   (fr_data)
    );

    pipe_stage #(.payload_t(framed_t)) s1 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (fr_valid),
        .in_ready  (s1_ready),
        .in_data   (fr_data),
        .out_valid (s1_valid),
        .out_ready (s2_ready),
        .out_data  (s1_data)
    );

    window_sum u_window (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_data (s1_data),
        .advance (advance),
        .sums    (sum_data)
    );

    pipe_stage #(.payload_t(sum_t)) s2 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (s1_valid),
        .in_ready  (s2_ready),
        .in_data   (sum_data),
        .out_valid (s2_valid),
        .out_ready (s3_ready),
        .out_data  (s2_data)
    );

    blur_select u_select (
        .in_data  (s2_data),
        .out_beat (sel_beat)
    );

    // output register drives the stream port directly
    pipe_stage #(.payload_t(pix_beat_t)) s3 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (s2_valid),
        .in_ready  (s3_ready),
        .in_data   (sel_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_beat)
    );

endmodule

`default_nettype wire

// File: hw/pipe_stage.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // take a new beat when empty or when the held one drains this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            // drained with nothing behind it
            full <= 1'b0;
        end
    end

    // payload only, occupancy lives in full
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/pix_framer.sv
`timescale 1ns/10ps
`default_nettype none

module pix_framer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  blur_pkg::pix_beat_t in_beat,
    input  logic                mask_frame,
    output logic                out_valid,
    input  logic                out_ready,
    output blur_pkg::framed_t   out_data
);
    import blur_pkg::*;

    // low until the first sop after reset
    logic             in_frame;
    logic             mask_q;
    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic             fwd;

    // ready is passed through, so idle beats are consumed and dropped
    assign in_ready  = out_ready;
    assign out_valid = in_valid && (in_frame || in_beat.sop);
    assign fwd       = out_valid && out_ready;

    always_comb begin
        out_data.beat = in_beat;
        if (in_beat.sop) begin
            // sop restarts at the origin, with the flag sampled now
            out_data.row  = '0;
            out_data.col  = '0;
            out_data.mask = mask_frame;
        end else begin
            out_data.row  = row_q;
            out_data.col  = col_q;
            out_data.mask = mask_q;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_frame <= 1'b0;
            mask_q   <= 1'b0;
            col_q    <= '0;
            row_q    <= '0;
        end else if (fwd) begin
            if (in_beat.sop) begin
                in_frame <= 1'b1;
                mask_q   <= mask_frame;
                // sop pixel sat at column 0
                col_q    <= COL_W'(1);
                row_q    <= '0;
            end else if (col_q == COL_W'(IMG_W - 1)) begin
                // end of line
                col_q <= '0;
                row_q <= row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/window_sum.sv
`timescale 1ns/10ps
`default_nettype none

module window_sum (
    input  logic              clk,
    input  logic              arst_n,
    input  blur_pkg::framed_t in_data,
    input  logic              advance,
    output blur_pkg::sum_t    sums
);
    import blur_pkg::*;

    // lb[k][c] holds the pixel of row r-1-k at column c
    rgb_t lb [KERNEL_DIM-1][IMG_W];
    // win[j] is the column c-1-j, entry i is row r-i
    rgb_t win [KERNEL_DIM-1][KERNEL_DIM];
    // window as seen by the current pixel
    rgb_t win_eff [KERNEL_DIM-1][KERNEL_DIM];
    // column c, built from the incoming pixel and the line buffers
    rgb_t col_now [KERNEL_DIM];
    logic first_col;

    assign first_col = (in_data.col == '0);

    always_comb begin
        col_now[0] = in_data.beat.pix;
        for (int k = 1; k < KERNEL_DIM; k++) begin
            // rows above the frame read as zero
            if (int'(in_data.row) < k) begin
                col_now[k] = '0;
            end else begin
                col_now[k] = lb[k-1][in_data.col];
            end
        end
    end

    // left edge of a line sees an empty window
    always_comb begin
        for (int j = 0; j < KERNEL_DIM - 1; j++) begin
            for (int i = 0; i < KERNEL_DIM; i++) begin
                if (first_col) begin
                    win_eff[j][i] = '0;
                end else begin
                    win_eff[j][i] = win[j][i];
                end
            end
        end
    end

    // plain adder tree over 25 taps per channel
    always_comb begin
        sums.beat  = in_data.beat;
        sums.mask  = in_data.mask;
        sums.sum_r = '0;
        sums.sum_g = '0;
        sums.sum_b = '0;
        for (int i = 0; i < KERNEL_DIM; i++) begin
            sums.sum_r = sums.sum_r + SUM_W'(col_now[i].r);
            sums.sum_g = sums.sum_g + SUM_W'(col_now[i].g);
            sums.sum_b = sums.sum_b + SUM_W'(col_now[i].b);
            for (int j = 0; j < KERNEL_DIM - 1; j++) begin
                sums.sum_r = sums.sum_r + SUM_W'(win_eff[j][i].r);
                sums.sum_g = sums.sum_g + SUM_W'(win_eff[j][i].g);
                sums.sum_b = sums.sum_b + SUM_W'(win_eff[j][i].b);
            end
        end
    end

    // window shifts one column per accepted pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int j = 0; j < KERNEL_DIM - 1; j++) begin
                for (int i = 0; i < KERNEL_DIM; i++) begin
                    win[j][i] <= '0;
                end
            end
        end else if (advance) begin
            for (int i = 0; i < KERNEL_DIM; i++) begin
                win[0][i] <= col_now[i];
                for (int j = 1; j < KERNEL_DIM - 1; j++) begin
                    win[j][i] <= win_eff[j-1][i];
                end
            end
        end
    end

    // push the pixel down the column, oldest row falls off
    always_ff @(posedge clk) begin
        if (advance) begin
            lb[0][in_data.col] <= in_data.beat.pix;
            for (int k = 1; k < KERNEL_DIM - 1; k++) begin
                lb[k][in_data.col] <= lb[k-1][in_data.col];
            end
        end
    end

endmodule

`default_nettype wire

// File: sources.f
hw/blur_pkg.sv
hw/pipe_stage.sv
hw/pix_framer.sv
hw/window_sum.sv
hw/blur_select.sv
hw/blur_top.sv
dv/clk_gen.sv
dv/blur_tb.sv
